//--- Makefile
# Verilator build and run of the execute slice testbench

VERILATOR ?= verilator
TOP       ?= tb_exec_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "FAIL"; exit 1; \
	elif grep -q "Done: no errors" $(LOG); then echo "PASS"; \
	else echo "FAIL: no result line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
+incdir+common
common/rv_pkg.sv
hw/ex/alu_control.sv
hw/ex/forwarding_unit.sv
hw/ex/alu.sv
hw/ex/ex_stage.sv
hw/reg_file.sv
hw/exec_top.sv
verification/tb_exec_top.sv

//--- common/rv_consts.svh
// register count, funct3 codes, ALU control codes and op-class codes
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define RV_NREGS 32

// RV32I funct3 for OP and OP-IMM
`define F3_ADD  3'b000
`define F3_SLL  3'b001
`define F3_SLT  3'b010
`define F3_SLTU 3'b011
`define F3_XOR  3'b100
`define F3_SR   3'b101
`define F3_OR   3'b110
`define F3_AND  3'b111

`define ALU_ADD  4'd0
`define ALU_SUB  4'd1
`define ALU_SLL  4'd2
`define ALU_SLT  4'd3
`define ALU_SLTU 4'd4
`define ALU_XOR  4'd5
`define ALU_SRL  4'd6
`define ALU_SRA  4'd7
`define ALU_OR   4'd8
`define ALU_AND  4'd9

// instruction classes seen by the ALU decoder
`define OP_ADD 2'd0
`define OP_REG 2'd1
`define OP_IMM 2'd2

`endif

//--- common/rv_pkg.sv
// datapath types for the execute slice
// word, register index, ALU control, op class and write-back select
`include "rv_consts.svh"

package rv_pkg;

    // 32-bit data word
    typedef logic [31:0] word_t;

    typedef logic [$clog2(`RV_NREGS)-1:0] reg_addr_t;

    // holds one of the ALU_* codes
    typedef logic [3:0] alu_ctrl_t;

    // instruction class from decode
    typedef logic [1:0] alu_op_t;

    localparam alu_op_t OP_ADD = `OP_ADD;
    localparam alu_op_t OP_REG = `OP_REG;
    localparam alu_op_t OP_IMM = `OP_IMM;

    // write-back source
    typedef logic [1:0] wr_sel_t;

    localparam wr_sel_t WR_ALU = 2'd0;
    // link value for jal / jalr
    localparam wr_sel_t WR_PC4 = 2'd1;
    // lui passes the immediate straight through
    localparam wr_sel_t WR_IMM = 2'd2;

endpackage

//--- hw/ex/alu.sv
// RV32I integer ALU
// add, sub, shifts, compares and logic ops
`timescale 1ns/1ps
`include "rv_consts.svh"

module alu (
    input  rv_pkg::word_t     a_i,
    input  rv_pkg::word_t     b_i,
    input  rv_pkg::alu_ctrl_t alu_ctrl_i,
    output rv_pkg::word_t     y_o
);

    logic [4:0] shamt;

    // shift amount is the low 5 bits of b
    assign shamt = b_i[4:0];

    always_comb begin
        case (alu_ctrl_i)
            `ALU_ADD:  y_o = a_i + b_i;
            `ALU_SUB:  y_o = a_i - b_i;
            `ALU_SLL:  y_o = a_i << shamt;
            `ALU_SLT:  y_o = {31'b0, $signed(a_i) < $signed(b_i)};
            `ALU_SLTU: y_o = {31'b0, a_i < b_i};
            `ALU_XOR:  y_o = a_i ^ b_i;
            `ALU_SRL:  y_o = a_i >> shamt;
            `ALU_SRA:  y_o = $signed(a_i) >>> shamt;
            `ALU_OR:   y_o = a_i | b_i;
            `ALU_AND:  y_o = a_i & b_i;
            default:   y_o = '0;
        endcase
    end

endmodule

//--- hw/ex/alu_control.sv
// ALU decoder from op class, funct3 and instruction bit 30
`timescale 1ns/1ps
`include "rv_consts.svh"

module alu_control (
    input  rv_pkg::alu_op_t   alu_op_i,
    input  logic [2:0]        funct3_i,
    input  logic              bit30_i,
    output rv_pkg::alu_ctrl_t alu_ctrl_o
);

    import rv_pkg::*;

    always_comb begin
        alu_ctrl_o = `ALU_ADD;
        if (alu_op_i == OP_REG || alu_op_i == OP_IMM) begin
            case (funct3_i)
                // bit 30 is an immediate bit for addi, so only OP selects sub
                `F3_ADD:  alu_ctrl_o = (alu_op_i == OP_REG && bit30_i) ? `ALU_SUB : `ALU_ADD;
                `F3_SLL:  alu_ctrl_o = `ALU_SLL;
                `F3_SLT:  alu_ctrl_o = `ALU_SLT;
                `F3_SLTU: alu_ctrl_o = `ALU_SLTU;
                `F3_XOR:  alu_ctrl_o = `ALU_XOR;
                // srai keeps bit 30 in its imm field
                `F3_SR:   alu_ctrl_o = bit30_i ? `ALU_SRA : `ALU_SRL;
                `F3_OR:   alu_ctrl_o = `ALU_OR;
                `F3_AND:  alu_ctrl_o = `ALU_AND;
                default:  alu_ctrl_o = `ALU_ADD;
            endcase
        end

        // decode only sends the three op classes
        if (!$isunknown(alu_op_i)) begin
            a_op_legal: assert final (alu_op_i inside {OP_ADD, OP_REG, OP_IMM})
                else $error("alu_control: illegal op class %0h", alu_op_i);
        end
    end

endmodule

//--- hw/ex/ex_stage.sv
// execution stage
// operand muxes with forwarding, ALU, result select and store data
`timescale 1ns/1ps

module ex_stage (
    input  rv_pkg::word_t     rs1_data_i,
    input  rv_pkg::word_t     rs2_data_i,
    input  rv_pkg::word_t     fwd_data_i,
    input  rv_pkg::word_t     imm_i,
    input  rv_pkg::word_t     pc_plus_i,
    input  rv_pkg::reg_addr_t rs1_i,
    input  rv_pkg::reg_addr_t rs2_i,
    input  logic              wb_valid_i,
    input  logic              wb_we_i,
    input  rv_pkg::reg_addr_t wb_addr_i,
    input  logic [2:0]        funct3_i,
    input  logic              bit30_i,
    input  rv_pkg::alu_op_t   alu_op_i,
    input  logic              use_imm_i,
    input  rv_pkg::wr_sel_t   wr_sel_i,
    output rv_pkg::word_t     result_o,
    output rv_pkg::word_t     store_data_o
);

    import rv_pkg::*;

    alu_ctrl_t alu_ctrl;
    logic      fwd1;
    logic      fwd2;
    word_t     op1;
    word_t     rs2_val;
    word_t     op2;
    word_t     alu_y;

    alu_control u_alu_control (
        .alu_op_i   (alu_op_i),
        .funct3_i   (funct3_i),
        .bit30_i    (bit30_i),
        .alu_ctrl_o (alu_ctrl)
    );

    forwarding_unit u_forwarding_unit (
        .rs1_i      (rs1_i),
        .rs2_i      (rs2_i),
        .wb_valid_i (wb_valid_i),
        .wb_we_i    (wb_we_i),
        .wb_addr_i  (wb_addr_i),
        .fwd1_o     (fwd1),
        .fwd2_o     (fwd2)
    );

    assign op1     = fwd1 ? fwd_data_i : rs1_data_i;
    assign rs2_val = fwd2 ? fwd_data_i : rs2_data_i;
    // store data is rs2 before the immediate mux
    assign store_data_o = rs2_val;
    assign op2          = use_imm_i ? imm_i : rs2_val;

    alu u_alu (
        .a_i        (op1),
        .b_i        (op2),
        .alu_ctrl_i (alu_ctrl),
        .y_o        (alu_y)
    );

    always_comb begin
        case (wr_sel_i)
            WR_PC4:  result_o = pc_plus_i;
            WR_IMM:  result_o = imm_i;
            default: result_o = alu_y;
        endcase

        // decode never emits the fourth select code
        if (!$isunknown(wr_sel_i)) begin
            a_wr_sel_legal: assert final (wr_sel_i inside {WR_ALU, WR_PC4, WR_IMM})
                else $error("ex_stage: illegal wr_sel %0h", wr_sel_i);
        end
    end

endmodule

//--- hw/ex/forwarding_unit.sv
// forward selects from the pending write-back
`timescale 1ns/1ps

module forwarding_unit (
    input  rv_pkg::reg_addr_t rs1_i,
    input  rv_pkg::reg_addr_t rs2_i,
    input  logic              wb_valid_i,
    input  logic              wb_we_i,
    input  rv_pkg::reg_addr_t wb_addr_i,
    output logic              fwd1_o,
    output logic              fwd2_o
);

    logic wb_live;

    // a write-back counts only if it will really land in the file
    assign wb_live = wb_valid_i && wb_we_i && (wb_addr_i != '0);

    assign fwd1_o = wb_live && (wb_addr_i == rs1_i);
    assign fwd2_o = wb_live && (wb_addr_i == rs2_i);

endmodule

//--- hw/exec_top.sv
// execute slice top level
// register file, execution stage and the write-back register
`timescale 1ns/1ps

module exec_top (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              issue_i,
    input  rv_pkg::reg_addr_t rs1_i,
    input  rv_pkg::reg_addr_t rs2_i,
    input  rv_pkg::reg_addr_t rd_i,
    input  logic              we_i,
    input  rv_pkg::word_t     imm_i,
    input  logic [2:0]        funct3_i,
    input  logic              bit30_i,
    input  rv_pkg::alu_op_t   alu_op_i,
    input  logic              use_imm_i,
    input  rv_pkg::wr_sel_t   wr_sel_i,
    input  rv_pkg::word_t     pc_plus_i,
    output logic              result_valid_o,
    output rv_pkg::word_t     result_o,
    output rv_pkg::reg_addr_t result_rd_o,
    output rv_pkg::word_t     store_data_o
);

    import rv_pkg::*;

    word_t     rs1_data;
    word_t     rs2_data;
    word_t     ex_result;
    word_t     ex_store;
    logic      wb_valid;
    logic      wb_we;
    reg_addr_t wb_addr;
    word_t     wb_data;
    word_t     wb_store;

    reg_file u_reg_file (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .raddr1_i (rs1_i),
        .raddr2_i (rs2_i),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data),
        .we_i     (wb_valid && wb_we),
        .waddr_i  (wb_addr),
        .wdata_i  (wb_data)
    );

    ex_stage u_ex_stage (
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .fwd_data_i   (wb_data),
        .imm_i        (imm_i),
        .pc_plus_i    (pc_plus_i),
        .rs1_i        (rs1_i),
        .rs2_i        (rs2_i),
        .wb_valid_i   (wb_valid),
        .wb_we_i      (wb_we),
        .wb_addr_i    (wb_addr),
        .funct3_i     (funct3_i),
        .bit30_i      (bit30_i),
        .alu_op_i     (alu_op_i),
        .use_imm_i    (use_imm_i),
        .wr_sel_i     (wr_sel_i),
        .result_o     (ex_result),
        .store_data_o (ex_store)
    );

    // write-back register, one per issued instruction
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_valid <= 1'b0;
            wb_we    <= 1'b0;
            wb_addr  <= '0;
            wb_data  <= '0;
            wb_store <= '0;
        end else begin
            wb_valid <= issue_i;
            if (issue_i) begin
                wb_we    <= we_i;
                wb_addr  <= rd_i;
                wb_data  <= ex_result;
                wb_store <= ex_store;
            end
        end
    end

    assign result_valid_o = wb_valid;
    assign result_o       = wb_data;
    assign result_rd_o    = wb_addr;
    assign store_data_o   = wb_store;

    // a valid pulse always carries known data
    a_result_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        result_valid_o |-> !$isunknown({result_o, result_rd_o, store_data_o}))
        else $error("exec_top: unknown result data on a valid pulse");

endmodule

//--- hw/reg_file.sv
// 32 x 32 register file
// two asynchronous read ports, one synchronous write port, x0 reads zero
`timescale 1ns/1ps
`include "rv_consts.svh"

module reg_file (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  rv_pkg::reg_addr_t raddr1_i,
    input  rv_pkg::reg_addr_t raddr2_i,
    output rv_pkg::word_t     rdata1_o,
    output rv_pkg::word_t     rdata2_o,
    input  logic              we_i,
    input  rv_pkg::reg_addr_t waddr_i,
    input  rv_pkg::word_t     wdata_i
);

    import rv_pkg::*;

    word_t regs [`RV_NREGS];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 is hardwired
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

//--- verification/tb_exec_top.sv
// testbench for exec_top
// random instruction stream checked against a register-file model
`timescale 1ns/1ps
`include "rv_consts.svh"

module tb_exec_top;

    import rv_pkg::*;

    logic       clk_i, arst_n_i, issue_i, we_i, bit30_i, use_imm_i, result_valid_o;
    reg_addr_t  rs1_i, rs2_i, rd_i, result_rd_o;
    word_t      imm_i, pc_plus_i, result_o, store_data_o;
    logic [2:0] funct3_i;
    alu_op_t    alu_op_i;
    wr_sel_t    wr_sel_i;

    // architectural register model, written at issue time
    word_t       mregs [32];
    word_t       exp_res [$];
    word_t       exp_store [$];
    reg_addr_t   exp_rd [$];
    word_t       e_res, e_store;
    reg_addr_t   e_rd;
    logic [31:0] rng = 32'd71158;
    logic        armed = 1'b0;
    logic        issue_seen = 1'b0;
    int          errors = 0;
    int          chk_errors = 0;
    int          tests = 0;
    int          failed = 0;

    exec_top u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    function automatic logic [31:0] rnd();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // RV32I behavior of the integer ops
    function automatic word_t alu_model(alu_op_t op, logic [2:0] f3, logic b30,
            word_t a, word_t b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        sa = a;
        sb = b;
        if (op == OP_ADD)
            return a + b;
        case (f3)
            `F3_ADD:  return (op == OP_REG && b30) ? a - b : a + b;
            `F3_SLL:  return a << b[4:0];
            `F3_SLT:  return (sa < sb) ? 32'd1 : 32'd0;
            `F3_SLTU: return (a < b) ? 32'd1 : 32'd0;
            `F3_XOR:  return a ^ b;
            `F3_SR: begin
                sa = sa >>> b[4:0];
                return b30 ? sa : a >> b[4:0];
            end
            `F3_OR:   return a | b;
            default:  return a & b;
        endcase
    endfunction

    // queues the expected response, then drives the instruction on the next edge
    task automatic issue_op(input reg_addr_t s1, input reg_addr_t s2, input reg_addr_t d,
            input logic wen, input word_t iv, input logic [2:0] f3, input logic b30,
            input alu_op_t op, input wr_sel_t ws);
        word_t pc;
        word_t res;
        pc = rnd();
        case (ws)
            WR_PC4:  res = pc;
            WR_IMM:  res = iv;
            default: res = alu_model(op, f3, b30, mregs[s1], (op == OP_IMM) ? iv : mregs[s2]);
        endcase
        exp_res.push_back(res);
        exp_store.push_back(mregs[s2]);
        exp_rd.push_back(d);
        if (wen && d != '0)
            mregs[d] = res;
        @(posedge clk_i);
        issue_i   <= 1'b1;
        rs1_i     <= s1;
        rs2_i     <= s2;
        rd_i      <= d;
        we_i      <= wen;
        imm_i     <= iv;
        funct3_i  <= f3;
        bit30_i   <= b30;
        alu_op_i  <= op;
        use_imm_i <= (op == OP_IMM);
        wr_sel_i  <= ws;
        pc_plus_i <= pc;
    endtask

    task automatic idle();
        @(posedge clk_i);
        issue_i <= 1'b0;
    endtask

    // drain outstanding results, then one report line
    task automatic end_test(input string name, input int mark);
        int waited = 0;
        idle();
        while (exp_res.size() != 0 && waited < 8) begin
            @(posedge clk_i);
            waited++;
        end
        results_arrived: assert (exp_res.size() == 0) else begin
            $display("%s: timed out with %0d results never returned", name, exp_res.size());
            errors++;
        end
        tests++;
        if (errors + chk_errors != mark)
            failed++;
        $display("test %s: %s, %0d errors", name,
                 (errors + chk_errors == mark) ? "ok" : "failed", errors + chk_errors - mark);
    endtask

    // one result per issue, one cycle later, in issue order
    always @(negedge clk_i) begin
        if (armed) begin
            valid_timing: assert (result_valid_o == issue_seen) else begin
                $display("[ERROR] result_valid_o expected %h got %h", issue_seen, result_valid_o);
                chk_errors++;
            end
            if (result_valid_o && exp_res.size() != 0) begin
                e_res   = exp_res.pop_front();
                e_store = exp_store.pop_front();
                e_rd    = exp_rd.pop_front();
                result_ok: assert (result_o == e_res) else begin
                    $display("[ERROR] result_o expected %h got %h", e_res, result_o);
                    chk_errors++;
                end
                store_ok: assert (store_data_o == e_store) else begin
                    $display("[ERROR] store_data_o expected %h got %h", e_store, store_data_o);
                    chk_errors++;
                end
                rd_ok: assert (result_rd_o == e_rd) else begin
                    $display("[ERROR] result_rd_o expected %h got %h", e_rd, result_rd_o);
                    chk_errors++;
                end
            end
        end
        issue_seen = issue_i;
    end

    initial begin
        reg_addr_t prev;
        reg_addr_t d;
        word_t     r;
        int        mark;
        foreach (mregs[i])
            mregs[i] = '0;
        {issue_i, we_i, bit30_i, use_imm_i, funct3_i} <= '0;
        {rs1_i, rs2_i, rd_i, alu_op_i, wr_sel_i} <= '0;
        {imm_i, pc_plus_i} <= '0;
        arst_n_i <= 1'b1;
        @(posedge clk_i);
        arst_n_i <= 1'b0;
        armed    <= 1'b1;
        repeat (16) @(posedge clk_i);
        arst_n_i <= 1'b1;

        // every register reads zero on both ports
        mark = errors + chk_errors;
        for (int i = 0; i < 32; i++)
            issue_op(i[4:0], 5'd31 - i[4:0], '0, 1'b1, '0, `F3_ADD, 1'b0, OP_REG, WR_ALU);
        end_test("reset", mark);

        mark = errors + chk_errors;
        for (int n = 0; n < 300; n++) begin
            r = rnd();
            issue_op(r[4:0], r[9:5], r[14:10], 1'b1, rnd(), r[17:15], r[18],
                     r[19] ? OP_IMM : OP_REG, WR_ALU);
        end
        end_test("alu_ops", mark);

        // each instruction reads the previous rd on one operand
        mark = errors + chk_errors;
        prev = 5'd1;
        issue_op('0, '0, prev, 1'b1, rnd(), `F3_ADD, 1'b0, OP_IMM, WR_ALU);
        for (int n = 0; n < 60; n++) begin
            r = rnd();
            d = (r[4:0] == '0) ? 5'd7 : r[4:0];
            issue_op(r[9] ? prev : r[14:10], r[9] ? r[19:15] : prev, d, 1'b1, rnd(),
                     r[7:5], r[8], r[20] ? OP_IMM : OP_REG, WR_ALU);
            prev = d;
        end
        end_test("back_to_back", mark);

        mark = errors + chk_errors;
        for (int n = 0; n < 30; n++) begin
            r = rnd();
            d = (r[4:0] == '0) ? 5'd3 : r[4:0];
            issue_op(r[9:5], '0, d, 1'b1, rnd(), r[12:10], r[13], OP_IMM, WR_ALU);
            idle();
            issue_op(d, d, r[18:14], 1'b1, '0, r[21:19], r[22], OP_REG, WR_ALU);
        end
        end_test("gap", mark);

        // link and lui results, x0 and we low never visible later
        mark = errors + chk_errors;
        for (int n = 0; n < 40; n++) begin
            r = rnd();
            d = r[5] ? '0 : r[4:0];
            issue_op(r[10:6], r[15:11], d, r[16], rnd(), `F3_ADD, 1'b0, OP_REG,
                     r[17] ? WR_PC4 : WR_IMM);
            issue_op(d, d, r[22:18], 1'b0, '0, `F3_OR, 1'b0, OP_REG, WR_ALU);
            idle();
            issue_op(d, d, r[27:23], 1'b1, '0, `F3_OR, 1'b0, OP_REG, WR_ALU);
        end
        end_test("wr_sel_x0", mark);

        mark = errors + chk_errors;
        for (int n = 0; n < 80; n++) begin
            r = rnd();
            if (r[0])
                issue_op(r[5:1], r[10:6], r[15:11], r[16], rnd(), r[19:17], r[20],
                         r[21] ? OP_ADD : OP_IMM, WR_ALU);
            else
                idle();
        end
        end_test("latency", mark);

        $display("%0d tests, %0d failed, %0d errors", tests, failed, errors + chk_errors);
        if (errors + chk_errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule
